//--- dv/frame_generator_tb.sv
`timescale 1ns/100ps
`include "frame_defs.svh"

module frame_generator_tb;

  localparam int FRAME_LEN = 2 * `FRAME_WORDS + 4;  // header, data and footer halves

  logic                   RD_CLK;
  logic                   RD_RESETN;
  frame_pkg::preLen_t     preLen;
  logic                   sampleValid;
  logic                   sampleReady;
  frame_pkg::sampleWord_t sampleData;
  logic                   trigger;
  frame_pkg::timeStamp_t  timeStamp;
  logic                   outValid;
  logic                   outReady;
  frame_pkg::outWord_t    outData;

  frame_pkg::outWord_t expWords [FRAME_LEN];  // reference stream of the current frame
  logic [15:0]         lfsrState;
  int                  frameCnt;

  frame_generator #(.CHANNEL_ID(3)) dut_i (
    .RD_CLK(RD_CLK), .RD_RESETN(RD_RESETN),
    .preLen(preLen), .sampleValid(sampleValid), .sampleReady(sampleReady),
    .sampleData(sampleData), .trigger(trigger), .timeStamp(timeStamp),
    .outValid(outValid), .outReady(outReady), .outData(outData)
  );

  initial begin
    RD_CLK = 1'b0;
    forever #10 RD_CLK = ~RD_CLK;  // 20 ns period
  end

  // taps x^16 + x^14 + x^13 + x^11 stepped once per bit
  function automatic logic [15:0] lfsrNext(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // mode 1 pulls one lfsr bit and mode 0 keeps ready high
  function automatic logic pickReady(input int mode);
    if (mode != 0) begin
      lfsrState = lfsrNext(lfsrState);
      return lfsrState[0];
    end
    return 1'b1;
  endfunction

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic checkValue(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      abortRun($sformatf("mismatch at time %0t: %s is %h, expected %h", $time, name, got, exp));
    end
  endtask

  // expected header, data and footer words of one frame
  task automatic buildExpected(input int pre, input int nPre, input logic [15:0] base,
                               input frame_pkg::timeStamp_t tsBase, input int frameNum);
    frame_pkg::timeStamp_t trigTs;
    logic [63:0]           head;
    logic [63:0]           foot;
    logic [63:0]           word;
    logic [15:0]           lane;
    trigTs = tsBase + 48'(nPre);  // stamp of the trigger sample
    head = {`HEADER_MARKER, 8'd3, 24'(frameNum), trigTs[23:0]};
    foot = {`FOOTER_MARKER, trigTs, 8'(`FRAME_WORDS)};
    expWords[0] = head[63:32];  // upper half leaves first
    expWords[1] = head[31:0];
    for (int j = 0; j < `FRAME_WORDS; j++) begin
      lane = base + 16'(nPre - pre + j);  // first pre-trigger sample onward
      word = {4{lane}};
      expWords[2 + 2 * j] = word[63:32];
      expWords[3 + 2 * j] = word[31:0];
    end
    expWords[FRAME_LEN - 2] = foot[63:32];
    expWords[FRAME_LEN - 1] = foot[31:0];
  endtask

  // drive one sample on the first falling edge that sees sampleReady
  task automatic offerSample(input logic [15:0] val, input frame_pkg::timeStamp_t ts,
                             input logic trig);
    int waitCnt;
    waitCnt = 0;
    @(negedge RD_CLK);
    while (!sampleReady) begin
      sampleValid = 1'b0;
      trigger     = 1'b0;
      waitCnt++;
      if (waitCnt > 100) abortRun("sampleReady stayed low while a sample was due");
      @(negedge RD_CLK);
    end
    sampleValid = 1'b1;
    sampleData  = {4{val}};
    timeStamp   = ts;
    trigger     = trig;
  endtask

  // history samples, two idle cycles to arm, then the trigger sample
  task automatic runPreTrigger(input int nPre, input logic [15:0] base,
                               input frame_pkg::timeStamp_t tsBase);
    outReady = 1'b1;
    for (int k = 0; k < nPre; k++) begin
      offerSample(base + 16'(k), tsBase + 48'(k), 1'b0);
      checkValue("outValid", outValid, 0);  // nothing out before a trigger
    end
    repeat (2) begin
      @(negedge RD_CLK);
      sampleValid = 1'b0;
      checkValue("outValid", outValid, 0);
    end
    offerSample(base + 16'(nPre), tsBase + 48'(nPre), 1'b1);
    checkValue("outValid", outValid, 0);
  endtask

  // post-trigger samples then junk samples with triggers during hold-off
  task automatic driveFrameTail(input int pre, input int nPre, input logic [15:0] base,
                                input frame_pkg::timeStamp_t tsBase);
    int junkCnt;
    int waitCnt;
    for (int i = 1; i < `FRAME_WORDS - pre; i++) begin
      offerSample(base + 16'(nPre + i), tsBase + 48'(nPre + i), 1'b0);
    end
    junkCnt = 0;
    waitCnt = 0;
    @(negedge RD_CLK);
    while (!sampleReady) begin
      sampleValid = 1'b1;  // must be dropped
      trigger     = 1'b1;
      sampleData  = {4{16'hE000 + 16'(junkCnt)}};
      timeStamp   = 48'hEEEE_0000_0000 + 48'(junkCnt);
      junkCnt++;
      waitCnt++;
      if (waitCnt > 2000) abortRun("sampleReady did not rise again after the frame readout");
      @(negedge RD_CLK);
    end
    sampleValid = 1'b0;
    trigger     = 1'b0;
    if (junkCnt == 0) abortRun("sampleReady never dropped while the frame was held");
  endtask

  // take each output word once on the falling edge before its transfer
  task automatic collectFrame(input int mode);
    int waitCnt;
    for (int i = 0; i < FRAME_LEN; i++) begin
      waitCnt = 0;
      @(negedge RD_CLK);
      outReady = pickReady(mode);
      while (!(outValid && outReady)) begin
        waitCnt++;
        if (waitCnt > 500) begin
          abortRun($sformatf("no output word %0d of frame %0d within 500 cycles", i, frameCnt));
        end
        @(negedge RD_CLK);
        outReady = pickReady(mode);
      end
      checkValue($sformatf("outData word %0d", i), outData, expWords[i]);
    end
  endtask

  initial begin
    int                    fd;
    int                    cnt;
    int                    pre;
    int                    nPre;
    int                    frameNum;
    int                    mode;
    logic [15:0]           base;
    frame_pkg::timeStamp_t tsBase;
    string                 line;
    RD_RESETN   = 1'b0;
    preLen      = '0;
    sampleValid = 1'b0;
    sampleData  = '0;
    trigger     = 1'b0;
    timeStamp   = '0;
    outReady    = 1'b1;
    lfsrState   = 16'd24999;
    frameCnt    = 0;
    repeat (5) @(negedge RD_CLK);  // five rising edges in reset
    RD_RESETN = 1'b1;
    @(negedge RD_CLK);
    checkValue("outValid", outValid, 0);
    checkValue("sampleReady", sampleReady, 1);
    fd = $fopen("dv/frame_stimulus.txt", "r");
    if (fd == 0) abortRun("could not open dv/frame_stimulus.txt");
    while (!$feof(fd)) begin
      line = "";
      cnt = $fgets(line, fd);
      if (cnt <= 0 || line.len() == 0 || line[0] == "#") continue;
      cnt = $sscanf(line, "%d %d %h %h %d %d", pre, nPre, base, tsBase, frameNum, mode);
      if (cnt <= 0) continue;  // blank line
      if (cnt != 6 || nPre < pre) abortRun($sformatf("bad stimulus line: %s", line));
      preLen = frame_pkg::preLen_t'(pre);
      buildExpected(pre, nPre, base, tsBase, frameNum);
      runPreTrigger(nPre, base, tsBase);
      fork
        driveFrameTail(pre, nPre, base, tsBase);
        collectFrame(mode);
      join
      frameCnt++;
    end
    $fclose(fd);
    // no stray frame after the last one
    repeat (40) begin
      @(negedge RD_CLK);
      outReady = 1'b1;
      checkValue("outValid", outValid, 0);
    end
    if (frameCnt == 0) begin
      abortRun("the stimulus file held no frames");
    end else begin
      $display("Simulation PASSED");
      $finish;
    end
  end

endmodule

//--- dv/frame_stimulus.txt
# columns: preLen preSamples baseValue(hex) tsBase(hex) frameNumber readyMode
# sample k carries baseValue+k in all four lanes and timestamp tsBase+k
# readyMode 0 holds outReady high, 1 takes outReady from the LFSR
0 0  0100 000000001000 0 0
0 4  0200 000000002000 1 0
5 5  0300 000000003000 2 0
5 12 0400 000000004000 3 0
5 12 0400 000000004000 4 1
7 7  1000 00007FFFFFF8 5 1
7 30 2000 0000FFFFFFF0 6 0
3 40 FFF0 123456789ABC 7 1
1 1  0010 FFFFFFFFFFF0 8 1
6 20 4000 000000FFFFFA 9 0
2 9  7FFE 00000000001F 10 1
0 50 5000 0000ABCDEF00 11 1
4 4  0001 000000000000 12 0
0 0  0100 000000001000 13 1
7 60 8000 800000000000 14 0
3 3  C000 00000000C000 15 1
6 6  0A0A 0000000A0A0A 16 0
2 25 FF00 7FFFFFFFFFF0 17 1
1 8  3333 333333333333 18 0
4 11 ABCD 0000DEADBEEF 19 1

//--- filelist.f
+incdir+include
verilog/frame_pkg.sv
verilog/frame_mem_if.sv
verilog/frame_buffer_arbiter.sv
verilog/frame_capture.sv
verilog/frame_reader.sv
verilog/frame_generator.sv
dv/frame_generator_tb.sv

//--- include/frame_defs.svh
`ifndef FRAME_DEFS_SVH
`define FRAME_DEFS_SVH

// data words per frame including the trigger word
`define FRAME_WORDS 16

// shared buffer depth in 64-bit words
`define MEM_DEPTH 64

// longest pre-trigger history a frame can carry
`define PRE_MAX 7

// top byte of the 64-bit header
`define HEADER_MARKER 8'hA5

// top byte of the 64-bit footer
`define FOOTER_MARKER 8'h5A

// header and footer both leave upper half first

`endif

//--- verilog/frame_buffer_arbiter.sv
`timescale 1ns/100ps
`include "frame_defs.svh"

module frame_buffer_arbiter (
  input logic          RD_CLK,
  input logic          RD_RESETN,
  frame_mem_if.arbiter wrPort,  // capture side with top priority
  frame_mem_if.arbiter rdPort   // reader
);

  frame_pkg::sampleWord_t mem [`MEM_DEPTH];  // circular sample history
  frame_pkg::sampleWord_t rdDataQ;
  frame_pkg::sampleWord_t selWdata;
  frame_pkg::memAddr_t    selAddr;
  logic                   selWe;
  logic                   anyGrant;

  // sample stream never stalls so capture always wins
  assign wrPort.grant = wrPort.req;
  assign rdPort.grant = rdPort.req & ~wrPort.req;
  assign anyGrant     = wrPort.req | rdPort.req;

  // route the granted client to the single memory port
  always_comb begin
    if (wrPort.req) begin
      selAddr  = wrPort.addr;
      selWe    = wrPort.we;
      selWdata = wrPort.wdata;
    end else begin
      selAddr  = rdPort.addr;
      selWe    = rdPort.we;
      selWdata = rdPort.wdata;
    end
  end

  always_ff @(posedge RD_CLK) begin
    if (anyGrant) begin
      if (selWe) begin
        mem[selAddr] <= selWdata;  // write lands on the grant edge
      end else begin
        rdDataQ <= mem[selAddr];   // one cycle read latency
      end
    end
  end

  // one read register serves both clients
  assign wrPort.rdata = rdDataQ;
  assign rdPort.rdata = rdDataQ;

  // reader keeps its request and address until granted
  rdReqHeld: assert property (@(posedge RD_CLK) disable iff (!RD_RESETN)
    rdPort.req && !rdPort.grant |=> rdPort.req && $stable(rdPort.addr));

endmodule

//--- verilog/frame_capture.sv
`timescale 1ns/100ps
`include "frame_defs.svh"

module frame_capture (
  input  logic                   RD_CLK,
  input  logic                   RD_RESETN,
  input  frame_pkg::preLen_t     preLen,       // pre-trigger words per frame
  input  logic                   sampleValid,
  input  logic                   trigger,      // qualified by the sample handshake
  input  frame_pkg::sampleWord_t sampleData,
  input  frame_pkg::timeStamp_t  timeStamp,
  output logic                   sampleReady,
  input  logic                   readerBusy,
  output logic                   frameDone,    // one-cycle pulse
  output frame_pkg::memAddr_t    frameStart,   // first pre-trigger word
  output frame_pkg::timeStamp_t  frameStamp,   // trigger sample's time
  frame_mem_if.client            mem
);

  frame_pkg::captureState_t state;
  frame_pkg::memAddr_t      wrAddr;    // next history slot with natural wrap
  frame_pkg::preLen_t       histCnt;   // saturating count of words since last frame
  frame_pkg::wordCnt_t      postCnt;   // post-trigger words still to write
  logic                     busySeen;  // reader has picked the frame up
  logic                     wrote;
  logic                     trigHit;

  // samples are dropped while a frame waits for or sits in the reader
  assign sampleReady = (state != frame_pkg::HOLD) & ~readerBusy;

  assign mem.req   = sampleValid & sampleReady;
  assign mem.we    = sampleValid & sampleReady;  // capture only writes
  assign mem.addr  = wrAddr;
  assign mem.wdata = sampleData;

  assign wrote   = mem.req & mem.grant;
  assign trigHit = wrote & trigger & (state == frame_pkg::ARMED);

  always_ff @(posedge RD_CLK) begin
    if (!RD_RESETN) begin
      state     <= frame_pkg::FILL;
      wrAddr    <= '0;
      histCnt   <= '0;
      postCnt   <= '0;
      busySeen  <= 1'b0;
      frameDone <= 1'b0;
    end else begin
      frameDone <= 1'b0;
      if (wrote) wrAddr <= wrAddr + 1'b1;  // natural wrap at MEM_DEPTH
      case (state)
        frame_pkg::FILL: begin
          if (wrote && histCnt != frame_pkg::preLen_t'(`PRE_MAX)) begin
            histCnt <= histCnt + 1'b1;
          end
          if (histCnt >= preLen) state <= frame_pkg::ARMED;  // enough history
        end
        frame_pkg::ARMED: begin
          if (trigHit) begin
            // trigger word is written so count only the rest
            postCnt <= frame_pkg::wordCnt_t'(`FRAME_WORDS - 1)
                       - frame_pkg::wordCnt_t'(preLen);
            state   <= frame_pkg::POST;
          end
        end
        frame_pkg::POST: begin
          if (wrote) begin
            postCnt <= postCnt - 1'b1;
            if (postCnt == frame_pkg::wordCnt_t'(1)) begin
              state     <= frame_pkg::HOLD;
              frameDone <= 1'b1;  // cycle after the last write
            end
          end
        end
        frame_pkg::HOLD: begin
          // busy rises a cycle after frameDone and its fall ends the hold
          if (readerBusy) begin
            busySeen <= 1'b1;
          end else if (busySeen) begin
            busySeen <= 1'b0;
            histCnt  <= '0;  // fresh history for the next frame
            state    <= frame_pkg::FILL;
          end
        end
        default: state <= frame_pkg::FILL;
      endcase
    end
  end

  // frame descriptor updated only on an accepted trigger
  always_ff @(posedge RD_CLK) begin
    if (trigHit) begin
      frameStart <= wrAddr - frame_pkg::memAddr_t'(preLen);
      frameStamp <= timeStamp;
    end
  end

  // reader must pick up every finished frame
  busyFollowsDone: assert property (@(posedge RD_CLK) disable iff (!RD_RESETN)
    frameDone |=> readerBusy);

endmodule

//--- verilog/frame_generator.sv
`timescale 1ns/100ps

module frame_generator #(
  parameter int CHANNEL_ID = 0
) (
  input  logic                   RD_CLK,
  input  logic                   RD_RESETN,
  input  frame_pkg::preLen_t     preLen,
  input  logic                   sampleValid,
  output logic                   sampleReady,
  input  frame_pkg::sampleWord_t sampleData,
  input  logic                   trigger,
  input  frame_pkg::timeStamp_t  timeStamp,
  output logic                   outValid,
  input  logic                   outReady,
  output frame_pkg::outWord_t    outData
);

  // capture to reader descriptor
  logic                  frameDone;
  logic                  readerBusy;
  frame_pkg::memAddr_t   frameStart;
  frame_pkg::timeStamp_t frameStamp;

  frame_mem_if capMem ();  // capture write path
  frame_mem_if rdMem ();   // reader fetch path

  frame_capture capture_i (
    .RD_CLK(RD_CLK), .RD_RESETN(RD_RESETN),
    .preLen(preLen), .sampleValid(sampleValid), .trigger(trigger),
    .sampleData(sampleData), .timeStamp(timeStamp), .sampleReady(sampleReady),
    .readerBusy(readerBusy), .frameDone(frameDone),
    .frameStart(frameStart), .frameStamp(frameStamp),
    .mem(capMem.client)
  );

  frame_reader #(.CHANNEL_ID(CHANNEL_ID)) reader_i (
    .RD_CLK(RD_CLK), .RD_RESETN(RD_RESETN),
    .frameDone(frameDone), .frameStart(frameStart), .frameStamp(frameStamp),
    .readerBusy(readerBusy),
    .outValid(outValid), .outReady(outReady), .outData(outData),
    .mem(rdMem.client)
  );

  // shared buffer, capture ahead of reader
  frame_buffer_arbiter arbiter_i (
    .RD_CLK(RD_CLK), .RD_RESETN(RD_RESETN),
    .wrPort(capMem.arbiter),
    .rdPort(rdMem.arbiter)
  );

endmodule

//--- verilog/frame_mem_if.sv
`timescale 1ns/100ps

// one client's path into the shared frame buffer
interface frame_mem_if;

  logic                   req;    // access wanted this cycle
  logic                   we;     // write when granted, else read
  frame_pkg::memAddr_t    addr;
  frame_pkg::sampleWord_t wdata;
  logic                   grant;  // access done on this edge
  frame_pkg::sampleWord_t rdata;  // valid one cycle after granted read

  // capture or reader side
  modport client (
    output req,
    output we,
    output addr,
    output wdata,
    input  grant,
    input  rdata
  );

  // buffer side
  modport arbiter (
    input  req,
    input  we,
    input  addr,
    input  wdata,
    output grant,
    output rdata
  );

endinterface

//--- verilog/frame_pkg.sv
`include "frame_defs.svh"

package frame_pkg;

  // one buffer word, four adc samples in 16-bit lanes
  typedef logic [63:0] sampleWord_t;

  typedef logic [31:0] outWord_t;                         // output stream word
  typedef logic [$clog2(`MEM_DEPTH)-1:0] memAddr_t;       // 6 bits for 64 words
  typedef logic [47:0] timeStamp_t;                       // full timestamp
  typedef logic [$clog2(`PRE_MAX+1)-1:0] preLen_t;        // 0..7
  typedef logic [23:0] frameNum_t;                        // frame counter in header
  typedef logic [$clog2(`FRAME_WORDS):0] wordCnt_t;       // holds 0..16

  // capture side
  typedef enum logic [1:0] {
    FILL,   // building pre-trigger history
    ARMED,  // trigger accepted here only
    POST,   // writing post-trigger words
    HOLD    // frame owned by the reader
  } captureState_t;

  // reader side
  typedef enum logic [1:0] {
    IDLE, HEAD, DATA, FOOT
  } readerState_t;

endpackage

//--- verilog/frame_reader.sv
`timescale 1ns/100ps
`include "frame_defs.svh"

module frame_reader #(
  parameter int CHANNEL_ID = 0
) (
  input  logic                  RD_CLK,
  input  logic                  RD_RESETN,
  input  logic                  frameDone,
  input  frame_pkg::memAddr_t   frameStart,
  input  frame_pkg::timeStamp_t frameStamp,
  output logic                  readerBusy,
  output logic                  outValid,
  input  logic                  outReady,
  output frame_pkg::outWord_t   outData,
  frame_mem_if.client           mem
);

  frame_pkg::readerState_t state;
  frame_pkg::memAddr_t     rdAddr;     // next buffer word to fetch
  frame_pkg::wordCnt_t     issueCnt;   // granted reads this frame
  frame_pkg::wordCnt_t     sentCnt;    // data words fully sent
  frame_pkg::frameNum_t    frameNum;
  frame_pkg::sampleWord_t  stage [2];  // staging for words in flight
  logic [1:0]              stageCnt;
  logic                    wrPtr;      // staging write slot
  logic                    rdPtr;      // staging read slot
  logic                    inFlight;   // rdata lands this cycle
  logic                    half;       // low while the upper half is next
  logic                    lastOut;    // footer lower half sits on outData
  logic [63:0]             header;
  logic [63:0]             footer;
  logic [63:0]             item;       // 64-bit item now going out
  logic                    itemAvail;
  logic                    outFree;
  logic                    load;       // next half goes into outData
  logic                    itemDone;
  logic                    fetch;
  logic                    fetchGnt;
  logic                    push;
  logic                    pop;
  logic                    endOfFrame;

  assign header = {`HEADER_MARKER, 8'(CHANNEL_ID), frameNum, frameStamp[23:0]};
  assign footer = {`FOOTER_MARKER, frameStamp, 3'b000, sentCnt};

  // current 64-bit item and whether it is ready to go out
  always_comb begin
    case (state)
      frame_pkg::HEAD: begin
        item      = header;
        itemAvail = 1'b1;
      end
      frame_pkg::DATA: begin
        item      = stage[rdPtr];
        itemAvail = (stageCnt != 0);
      end
      frame_pkg::FOOT: begin
        item      = footer;
        itemAvail = ~lastOut;  // nothing left once the lower half is out
      end
      default: begin
        item      = header;
        itemAvail = 1'b0;
      end
    endcase
  end

  assign outFree    = ~outValid | outReady;  // output register can take a word
  assign load       = outFree & itemAvail;
  assign itemDone   = load & half;           // lower half leaving ends the item
  assign endOfFrame = outValid & outReady & lastOut;
  assign pop        = itemDone & (state == frame_pkg::DATA);
  assign push       = inFlight;

  // prefetch from the header on with at most two words outstanding
  assign fetch = (state == frame_pkg::HEAD || state == frame_pkg::DATA)
               && issueCnt != frame_pkg::wordCnt_t'(`FRAME_WORDS)
               && (stageCnt + {1'b0, inFlight}) < 2'd2;

  assign mem.req   = fetch;  // held with addr until grant
  assign mem.we    = 1'b0;
  assign mem.addr  = rdAddr;
  assign mem.wdata = '0;
  assign fetchGnt  = mem.req & mem.grant;

  always_ff @(posedge RD_CLK) begin
    if (!RD_RESETN) begin
      state <= frame_pkg::IDLE;
      readerBusy <= 1'b0;
      outValid <= 1'b0;
      half <= 1'b0;
      lastOut <= 1'b0;
      stageCnt <= '0;
      wrPtr <= 1'b0;
      rdPtr <= 1'b0;
      inFlight <= 1'b0;
      rdAddr <= '0;
      issueCnt <= '0;
      sentCnt <= '0;
      frameNum <= '0;
    end else begin
      inFlight <= fetchGnt;
      if (fetchGnt) begin
        rdAddr   <= rdAddr + 1'b1;  // wraps with the history
        issueCnt <= issueCnt + 1'b1;
      end
      if (push) wrPtr <= ~wrPtr;
      if (pop) begin
        rdPtr   <= ~rdPtr;
        sentCnt <= sentCnt + 1'b1;
      end
      stageCnt <= stageCnt + 2'(push) - 2'(pop);
      if (load) begin
        outValid <= 1'b1;
        half     <= ~half;
      end else if (outReady) begin
        outValid <= 1'b0;  // word taken with nothing behind it
      end
      case (state)
        frame_pkg::IDLE: if (frameDone) begin
          state      <= frame_pkg::HEAD;
          readerBusy <= 1'b1;
          rdAddr     <= frameStart;
          issueCnt   <= '0;
          sentCnt    <= '0;
        end
        frame_pkg::HEAD: if (itemDone) state <= frame_pkg::DATA;
        frame_pkg::DATA: begin
          if (pop && sentCnt == frame_pkg::wordCnt_t'(`FRAME_WORDS - 1)) state <= frame_pkg::FOOT;
        end
        frame_pkg::FOOT: begin
          if (itemDone) lastOut <= 1'b1;
          if (endOfFrame) begin  // second footer half transferred
            state      <= frame_pkg::IDLE;
            readerBusy <= 1'b0;
            lastOut    <= 1'b0;
            frameNum   <= frameNum + 1'b1;
          end
        end
        default: state <= frame_pkg::IDLE;
      endcase
    end
  end

  // payload registers
  always_ff @(posedge RD_CLK) begin
    if (push) stage[wrPtr] <= mem.rdata;
    if (load) outData <= half ? item[31:0] : item[63:32];  // upper half first
  end

  // a new frame must never arrive during a readout
  doneOnlyWhenIdle: assert property (@(posedge RD_CLK) disable iff (!RD_RESETN)
    frameDone |-> state == frame_pkg::IDLE);

endmodule
